//--- logic/ctrl_pkg.sv
// Shared widths, SPR addresses, bit positions and structs for the retire control unit
package ctrl_pkg;

   localparam int DATA_W     = 32;
   localparam int SPR_ADDR_W = 16;
   localparam int SR_W       = 16;

   // Supervisor mode plus the fixed-one bit 15
   localparam logic [SR_W-1:0] SR_RESET = 16'h8001;

   // System group
   localparam logic [SPR_ADDR_W-1:0] SPR_SR    = 16'h0011;
   localparam logic [SPR_ADDR_W-1:0] SPR_PPC   = 16'h0012;
   localparam logic [SPR_ADDR_W-1:0] SPR_EVBA  = 16'h0014;
   localparam logic [SPR_ADDR_W-1:0] SPR_EPCR  = 16'h0020;
   localparam logic [SPR_ADDR_W-1:0] SPR_EEAR  = 16'h0030;
   localparam logic [SPR_ADDR_W-1:0] SPR_ESR   = 16'h0040;
   // PIC and tick timer groups
   localparam logic [SPR_ADDR_W-1:0] SPR_PICMR = 16'h4800;
   localparam logic [SPR_ADDR_W-1:0] SPR_PICSR = 16'h4802;
   localparam logic [SPR_ADDR_W-1:0] SPR_TTMR  = 16'h5000;
   localparam logic [SPR_ADDR_W-1:0] SPR_TTCR  = 16'h5001;

   // Group number lives in address bits 15:11
   localparam logic [4:0] GRP_SYS = 5'd0;
   localparam logic [4:0] GRP_PIC = 5'd9;
   localparam logic [4:0] GRP_TT  = 5'd10;

   localparam int SR_SM  = 0;
   localparam int SR_TEE = 1;
   localparam int SR_IEE = 2;
   localparam int SR_F   = 9;
   localparam logic [SR_W-1:0] SR_WMASK =
      SR_W'((1 << SR_SM) | (1 << SR_TEE) | (1 << SR_IEE) | (1 << SR_F));

   // Offsets added onto EVBA
   localparam logic [DATA_W-1:0] VEC_BERR    = 32'h0000_0200;
   localparam logic [DATA_W-1:0] VEC_TT      = 32'h0000_0500;
   localparam logic [DATA_W-1:0] VEC_ALIGN   = 32'h0000_0600;
   localparam logic [DATA_W-1:0] VEC_ILLEGAL = 32'h0000_0700;
   localparam logic [DATA_W-1:0] VEC_INT     = 32'h0000_0800;
   localparam logic [DATA_W-1:0] VEC_SYSCALL = 32'h0000_0C00;
   localparam logic [DATA_W-1:0] VEC_TRAP    = 32'h0000_0E00;
   localparam int EVBA_LOW_W = 13;

   localparam int TT_IP       = 28;
   localparam int TT_IE       = 29;
   // Low bit of the two-bit mode field at 31:30
   localparam int TT_MODE     = 30;
   localparam int TT_PERIOD_W = 28;

   typedef enum logic [1:0] {OP_PLAIN, OP_MTSPR, OP_MFSPR, OP_RFE} op_kind_e;

   typedef struct packed {
      logic ibus_err;
      logic illegal;
      logic align;
      logic syscall;
      logic trap;
      logic dbus;
   } except_flags_t;

   typedef struct packed {
      op_kind_e                kind;
      logic [DATA_W-1:0]       pc;
      logic [SPR_ADDR_W-1:0]   spr_addr;
      logic [DATA_W-1:0]       wdata;
      logic [DATA_W-1:0]       lsu_adr;
      except_flags_t           flags;
   } ctrl_op_t;

   // Listed in rank order, highest first
   typedef enum logic [2:0] {
      CAUSE_IBUS_ERR, CAUSE_ILLEGAL, CAUSE_ALIGN, CAUSE_SYSCALL,
      CAUSE_TRAP, CAUSE_DBUS, CAUSE_PIC, CAUSE_TICK
   } cause_e;

   typedef struct packed {
      logic              take;
      cause_e            cause;
      logic [DATA_W-1:0] vector;
   } except_t;

   typedef struct packed {
      logic                  we;
      logic [SPR_ADDR_W-1:0] addr;
      logic [DATA_W-1:0]     data;
   } spr_wr_t;

   typedef struct packed {
      logic [DATA_W-1:0] rdata;
      logic              redirect;
      logic [DATA_W-1:0] redirect_pc;
   } ctrl_res_t;

endpackage

//--- logic/ctrl_retire_seq.sv
// Handshake sequencer: latches one op, pulses commit and registers the retire result
module ctrl_retire_seq (
   input  logic                        clk,
   input  logic                        rst,
   input  logic                        req_i,
   input  ctrl_pkg::ctrl_op_t          op_i,
   input  ctrl_pkg::except_t           except_i,
   input  logic [ctrl_pkg::DATA_W-1:0] sys_rdata_i,
   input  logic [ctrl_pkg::DATA_W-1:0] pic_rdata_i,
   input  logic [ctrl_pkg::DATA_W-1:0] tt_rdata_i,
   input  logic [ctrl_pkg::DATA_W-1:0] epcr_i,
   output logic                        ack_o,
   output ctrl_pkg::ctrl_res_t         res_o,
   output ctrl_pkg::ctrl_op_t          op_o,
   output logic                        commit_o,
   output logic                        rfe_commit_o,
   output ctrl_pkg::spr_wr_t           spr_wr_o
);

   typedef enum logic [1:0] {ST_IDLE, ST_COMMIT, ST_HOLD} state_e;

   state_e                      state;
   logic                        req_q;
   ctrl_pkg::ctrl_op_t          op_q;
   ctrl_pkg::ctrl_res_t         res_q;
   ctrl_pkg::ctrl_res_t         res_d;
   logic [4:0]                  grp;
   logic [ctrl_pkg::DATA_W-1:0] grp_rdata;

   assign commit_o = (state == ST_COMMIT);
   assign ack_o    = (state == ST_HOLD);
   assign op_o     = op_q;
   assign res_o    = res_q;
   assign grp      = op_q.spr_addr[15:11];

   // Side effects are dropped when the op is replaced by an exception
   assign spr_wr_o.we   = commit_o & (op_q.kind == ctrl_pkg::OP_MTSPR) & ~except_i.take;
   assign spr_wr_o.addr = op_q.spr_addr;
   assign spr_wr_o.data = op_q.wdata;
   assign rfe_commit_o  = commit_o & (op_q.kind == ctrl_pkg::OP_RFE) & ~except_i.take;

   always_comb begin
      case (grp)
         ctrl_pkg::GRP_SYS: grp_rdata = sys_rdata_i;
         ctrl_pkg::GRP_PIC: grp_rdata = pic_rdata_i;
         ctrl_pkg::GRP_TT:  grp_rdata = tt_rdata_i;
         default:           grp_rdata = '0;
      endcase
   end

   always_comb begin
      res_d.rdata       = '0;
      res_d.redirect    = 1'b0;
      res_d.redirect_pc = '0;
      if (except_i.take) begin
         res_d.redirect    = 1'b1;
         res_d.redirect_pc = except_i.vector;
      end else if (op_q.kind == ctrl_pkg::OP_RFE) begin
         res_d.redirect    = 1'b1;
         res_d.redirect_pc = epcr_i;
      end else if (op_q.kind == ctrl_pkg::OP_MFSPR) begin
         res_d.rdata = grp_rdata;
      end
   end

   // Request is registered once, so the FSM only ever sees a clean level
   always_ff @(posedge clk) begin
      if (rst) begin
         state <= ST_IDLE;
         req_q <= 1'b0;
      end else begin
         req_q <= req_i;
         case (state)
            ST_IDLE:   if (req_q) state <= ST_COMMIT;
            ST_COMMIT: state <= ST_HOLD;
            ST_HOLD:   if (!req_q) state <= ST_IDLE;
            default:   state <= ST_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == ST_IDLE && req_q) begin
         op_q <= op_i;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         res_q.redirect <= 1'b0;
      end else if (commit_o) begin
         res_q <= res_d;
      end
   end

endmodule

//--- logic/sys_spr_file.sv
// System group SPRs with exception save, rfe restore, mtspr writes and the group 0 read mux
module sys_spr_file (
   input  logic                        clk,
   input  logic                        rst,
   input  ctrl_pkg::ctrl_op_t          op_i,
   input  logic                        commit_i,
   input  logic                        rfe_commit_i,
   input  ctrl_pkg::spr_wr_t           spr_wr_i,
   input  ctrl_pkg::except_t           except_i,
   output logic [ctrl_pkg::DATA_W-1:0] rdata_o,
   output logic [ctrl_pkg::SR_W-1:0]   sr_o,
   output logic [ctrl_pkg::DATA_W-1:0] evba_o,
   output logic [ctrl_pkg::DATA_W-1:0] epcr_o
);

   logic [ctrl_pkg::SR_W-1:0]   sr;
   logic [ctrl_pkg::SR_W-1:0]   esr;
   logic [ctrl_pkg::DATA_W-1:0] epcr;
   logic [ctrl_pkg::DATA_W-1:0] eear;
   logic [ctrl_pkg::DATA_W-1:0] evba;
   logic [ctrl_pkg::DATA_W-1:0] ppc;
   logic                        resume_next;

   assign sr_o   = sr;
   assign evba_o = evba;
   assign epcr_o = epcr;

   // These causes resume after the op, the rest retry it
   assign resume_next = (except_i.cause == ctrl_pkg::CAUSE_SYSCALL) |
                        (except_i.cause == ctrl_pkg::CAUSE_TICK) |
                        (except_i.cause == ctrl_pkg::CAUSE_PIC);

   always_ff @(posedge clk) begin
      if (rst) begin
         sr <= ctrl_pkg::SR_RESET;
      end else if (except_i.take) begin
         sr[ctrl_pkg::SR_SM]  <= 1'b1;
         sr[ctrl_pkg::SR_TEE] <= 1'b0;
         sr[ctrl_pkg::SR_IEE] <= 1'b0;
      end else if (rfe_commit_i) begin
         sr <= esr;
      end else if (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_SR && sr[ctrl_pkg::SR_SM]) begin
         // Only SM, TEE, IEE and F take the new value
         sr <= (sr & ~ctrl_pkg::SR_WMASK) |
               (spr_wr_i.data[ctrl_pkg::SR_W-1:0] & ctrl_pkg::SR_WMASK);
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         esr <= ctrl_pkg::SR_RESET;
      end else if (except_i.take) begin
         esr <= sr;
      end else if (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_ESR) begin
         esr <= spr_wr_i.data[ctrl_pkg::SR_W-1:0];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         epcr <= '0;
      end else if (except_i.take) begin
         epcr <= resume_next ? op_i.pc + 32'd4 : op_i.pc;
      end else if (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_EPCR) begin
         epcr <= spr_wr_i.data;
      end
   end

   // Fetch errors report the PC, everything else the load/store address
   always_ff @(posedge clk) begin
      if (rst) begin
         eear <= '0;
      end else if (except_i.take) begin
         eear <= (except_i.cause == ctrl_pkg::CAUSE_IBUS_ERR) ? op_i.pc : op_i.lsu_adr;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         evba <= '0;
      end else if (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_EVBA) begin
         evba <= {spr_wr_i.data[ctrl_pkg::DATA_W-1:ctrl_pkg::EVBA_LOW_W],
                  {ctrl_pkg::EVBA_LOW_W{1'b0}}};
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ppc <= '0;
      end else if (commit_i) begin
         ppc <= op_i.pc;
      end
   end

   always_comb begin
      case (op_i.spr_addr)
         ctrl_pkg::SPR_SR:   rdata_o = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, sr};
         ctrl_pkg::SPR_ESR:  rdata_o = {{(ctrl_pkg::DATA_W-ctrl_pkg::SR_W){1'b0}}, esr};
         ctrl_pkg::SPR_PPC:  rdata_o = ppc;
         ctrl_pkg::SPR_EVBA: rdata_o = evba;
         ctrl_pkg::SPR_EPCR: rdata_o = epcr;
         ctrl_pkg::SPR_EEAR: rdata_o = eear;
         // Unimplemented addresses read as zero
         default:            rdata_o = '0;
      endcase
   end

endmodule

//--- logic/except_ctrl.sv
// Exception ranking at commit, giving the taken flag, the cause and the vector address
module except_ctrl (
   input  ctrl_pkg::ctrl_op_t          op_i,
   input  logic                        commit_i,
   input  logic [ctrl_pkg::SR_W-1:0]   sr_i,
   input  logic [ctrl_pkg::DATA_W-1:0] evba_i,
   input  logic                        tick_irq_i,
   input  logic                        pic_irq_i,
   output ctrl_pkg::except_t           except_o
);

   logic                        int_ok;
   logic                        pic_int;
   logic                        tick_int;
   logic                        pending;
   ctrl_pkg::cause_e            cause;
   logic [ctrl_pkg::DATA_W-1:0] offset;

   // Interrupts never land on an SPR write or a return
   assign int_ok   = (op_i.kind != ctrl_pkg::OP_MTSPR) && (op_i.kind != ctrl_pkg::OP_RFE);
   assign pic_int  = pic_irq_i & sr_i[ctrl_pkg::SR_IEE] & int_ok;
   assign tick_int = tick_irq_i & sr_i[ctrl_pkg::SR_TEE] & int_ok;
   assign pending  = (|op_i.flags) | pic_int | tick_int;

   always_comb begin
      cause  = ctrl_pkg::CAUSE_TICK;
      offset = ctrl_pkg::VEC_TT;
      if (op_i.flags.ibus_err) begin
         cause  = ctrl_pkg::CAUSE_IBUS_ERR;
         offset = ctrl_pkg::VEC_BERR;
      end else if (op_i.flags.illegal) begin
         cause  = ctrl_pkg::CAUSE_ILLEGAL;
         offset = ctrl_pkg::VEC_ILLEGAL;
      end else if (op_i.flags.align) begin
         cause  = ctrl_pkg::CAUSE_ALIGN;
         offset = ctrl_pkg::VEC_ALIGN;
      end else if (op_i.flags.syscall) begin
         cause  = ctrl_pkg::CAUSE_SYSCALL;
         offset = ctrl_pkg::VEC_SYSCALL;
      end else if (op_i.flags.trap) begin
         cause  = ctrl_pkg::CAUSE_TRAP;
         offset = ctrl_pkg::VEC_TRAP;
      end else if (op_i.flags.dbus) begin
         // Data bus errors share the bus error vector
         cause  = ctrl_pkg::CAUSE_DBUS;
         offset = ctrl_pkg::VEC_BERR;
      end else if (pic_int) begin
         cause  = ctrl_pkg::CAUSE_PIC;
         offset = ctrl_pkg::VEC_INT;
      end
   end

   assign except_o = '{take: commit_i & pending, cause: cause, vector: evba_i | offset};

endmodule

//--- logic/tick_timer.sv
// Tick timer with TTMR/TTCR registers, period match and the timer interrupt
module tick_timer (
   input  logic                            clk,
   input  logic                            rst,
   input  ctrl_pkg::spr_wr_t               spr_wr_i,
   input  logic [ctrl_pkg::SPR_ADDR_W-1:0] addr_i,
   output logic [ctrl_pkg::DATA_W-1:0]     rdata_o,
   output logic                            tick_irq_o
);

   logic [ctrl_pkg::DATA_W-1:0] ttmr;
   logic [ctrl_pkg::DATA_W-1:0] ttcr;
   logic [1:0]                  mode;
   logic                        match;
   logic                        wr_ttmr;
   logic                        wr_ttcr;

   assign mode    = ttmr[ctrl_pkg::TT_MODE +: 2];
   assign match   = ttmr[ctrl_pkg::TT_PERIOD_W-1:0] == ttcr[ctrl_pkg::TT_PERIOD_W-1:0];
   assign wr_ttmr = spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_TTMR;
   assign wr_ttcr = spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_TTCR;

   always_ff @(posedge clk) begin
      if (rst) begin
         ttmr <= '0;
      end else if (wr_ttmr) begin
         ttmr <= spr_wr_i.data;
         // A write can clear the pending bit but never set it
         ttmr[ctrl_pkg::TT_IP] <= spr_wr_i.data[ctrl_pkg::TT_IP] & ttmr[ctrl_pkg::TT_IP];
      end else if (mode != 2'd0 && match && ttmr[ctrl_pkg::TT_IE]) begin
         ttmr[ctrl_pkg::TT_IP] <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         ttcr <= '0;
      end else if (wr_ttcr) begin
         ttcr <= spr_wr_i.data;
      end else if (mode != 2'd0) begin
         if (match && mode == 2'd1) begin
            // Restart mode
            ttcr <= '0;
         end else if (!(match && mode == 2'd2)) begin
            ttcr <= ttcr + 32'd1;
         end
      end
   end

   assign tick_irq_o = ttmr[ctrl_pkg::TT_IP];

   always_comb begin
      case (addr_i)
         ctrl_pkg::SPR_TTMR: rdata_o = ttmr;
         ctrl_pkg::SPR_TTCR: rdata_o = ttcr;
         default:            rdata_o = '0;
      endcase
   end

endmodule

//--- logic/pic_ctrl.sv
// Edge-triggered interrupt controller with PICMR/PICSR and a single request out
module pic_ctrl (
   input  logic                            clk,
   input  logic                            rst,
   input  logic [31:0]                     irq_i,
   input  ctrl_pkg::spr_wr_t               spr_wr_i,
   input  logic [ctrl_pkg::SPR_ADDR_W-1:0] addr_i,
   output logic [ctrl_pkg::DATA_W-1:0]     rdata_o,
   output logic                            pic_irq_o
);

   logic [31:0] picmr;
   logic [31:0] picsr;
   logic [31:0] irq_q;
   logic [31:0] rise;
   logic [31:0] clr;

   assign rise = irq_i & ~irq_q & picmr;
   // Write one to clear
   assign clr  = (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_PICSR) ? spr_wr_i.data : '0;

   always_ff @(posedge clk) begin
      if (rst) begin
         irq_q <= '0;
         picmr <= '0;
         picsr <= '0;
      end else begin
         irq_q <= irq_i;
         if (spr_wr_i.we && spr_wr_i.addr == ctrl_pkg::SPR_PICMR) begin
            picmr <= spr_wr_i.data;
         end
         // New edge wins over a clear in the same cycle
         picsr <= (picsr & ~clr) | rise;
      end
   end

   assign pic_irq_o = |picsr;

   always_comb begin
      case (addr_i)
         ctrl_pkg::SPR_PICMR: rdata_o = picmr;
         ctrl_pkg::SPR_PICSR: rdata_o = picsr;
         default:             rdata_o = '0;
      endcase
   end

endmodule

//--- logic/ctrl_unit.sv
// Retire control unit top level, one req/ack handshake per retired operation
module ctrl_unit (
   input  logic                clk,
   input  logic                rst,
   input  logic                req_i,
   input  ctrl_pkg::ctrl_op_t  op_i,
   input  logic [31:0]         irq_i,
   output logic                ack_o,
   output ctrl_pkg::ctrl_res_t res_o
);

   ctrl_pkg::ctrl_op_t              op;
   ctrl_pkg::except_t               except;
   ctrl_pkg::spr_wr_t               spr_wr;
   logic                            commit;
   logic                            rfe_commit;
   logic [ctrl_pkg::DATA_W-1:0]     sys_rdata;
   logic [ctrl_pkg::DATA_W-1:0]     pic_rdata;
   logic [ctrl_pkg::DATA_W-1:0]     tt_rdata;
   logic [ctrl_pkg::DATA_W-1:0]     epcr;
   logic [ctrl_pkg::DATA_W-1:0]     evba;
   logic [ctrl_pkg::SR_W-1:0]       sr;
   logic                            tick_irq;
   logic                            pic_irq;

   ctrl_retire_seq u_seq (
      .clk(clk), .rst(rst), .req_i(req_i), .op_i(op_i), .except_i(except),
      .sys_rdata_i(sys_rdata), .pic_rdata_i(pic_rdata), .tt_rdata_i(tt_rdata),
      .epcr_i(epcr), .ack_o(ack_o), .res_o(res_o), .op_o(op), .commit_o(commit),
      .rfe_commit_o(rfe_commit), .spr_wr_o(spr_wr)
   );

   sys_spr_file u_spr (
      .clk(clk), .rst(rst), .op_i(op), .commit_i(commit), .rfe_commit_i(rfe_commit),
      .spr_wr_i(spr_wr), .except_i(except), .rdata_o(sys_rdata), .sr_o(sr),
      .evba_o(evba), .epcr_o(epcr)
   );

   except_ctrl u_exc (
      .op_i(op), .commit_i(commit), .sr_i(sr), .evba_i(evba),
      .tick_irq_i(tick_irq), .pic_irq_i(pic_irq), .except_o(except)
   );

   tick_timer u_tt (
      .clk(clk), .rst(rst), .spr_wr_i(spr_wr), .addr_i(op.spr_addr),
      .rdata_o(tt_rdata), .tick_irq_o(tick_irq)
   );

   pic_ctrl u_pic (
      .clk(clk), .rst(rst), .irq_i(irq_i), .spr_wr_i(spr_wr), .addr_i(op.spr_addr),
      .rdata_o(pic_rdata), .pic_irq_o(pic_irq)
   );

endmodule

//--- test/ctrl_unit_sva.sv
// Handshake and reset assertions for ctrl_unit, attached to every instance with bind
module ctrl_unit_sva (
   input logic                clk,
   input logic                rst,
   input logic                req_i,
   input logic                ack_o,
   input ctrl_pkg::ctrl_res_t res_o
);

   // Number of assertion failures so far
   int fail_count = 0;

   // Sequencer state is cleared by the synchronous reset
   ack_low_in_reset: assert property (@(posedge clk) rst |=> !ack_o)
      else begin
         $error("ack_o high while in reset");
         fail_count++;
      end

   ack_low_after_reset: assert property (@(posedge clk)
      $fell(rst) |-> (!ack_o && !res_o.redirect))
      else begin
         $error("ack_o or res_o.redirect high on the first cycle after reset");
         fail_count++;
      end

   ack_needs_req: assert property (@(posedge clk) disable iff (rst) $rose(ack_o) |-> req_i)
      else begin
         $error("ack_o rose while req_i was low");
         fail_count++;
      end

   res_stable: assert property (@(posedge clk) disable iff (rst)
      (ack_o && $past(ack_o)) |-> $stable(res_o))
      else begin
         $error("res_o changed while ack_o was high");
         fail_count++;
      end

endmodule

bind ctrl_unit ctrl_unit_sva u_sva (
   .clk(clk), .rst(rst), .req_i(req_i), .ack_o(ack_o), .res_o(res_o)
);

//--- test/tb_ctrl_unit.sv
// Testbench for ctrl_unit, drives retire ops over req/ack and checks results against a model
module tb_ctrl_unit;

   localparam int ACK_LIMIT  = 32;
   localparam int TICK_TRIES = 40;

   logic                clk;
   logic                rst;
   logic                req_i;
   ctrl_pkg::ctrl_op_t  op_i;
   logic [31:0]         irq_i;
   logic                ack_o;
   ctrl_pkg::ctrl_res_t res_o;

   integer              seed;
   int                  n_checks;
   int                  n_errors;
   logic [31:0]         pc_ctr;
   logic                check_en;
   logic                ack_seen;
   ctrl_pkg::ctrl_res_t exp_res;

   // Mirror of the architectural state
   logic [15:0] m_sr;
   logic [15:0] m_esr;
   logic [31:0] m_epcr;
   logic [31:0] m_eear;
   logic [31:0] m_evba;
   logic [31:0] m_ppc;
   logic [31:0] m_picmr;
   logic [31:0] m_picsr;

   ctrl_unit DUT (
      .clk(clk), .rst(rst), .req_i(req_i), .op_i(op_i), .irq_i(irq_i),
      .ack_o(ack_o), .res_o(res_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      n_checks++;
      if (got !== exp) begin
         n_errors++;
         $display("** Error at %0t: %s got %h expected %h", $time, name, got, exp);
      end
   endtask

   task automatic timed_out(input string what);
      $display("Timeout at %0t: %s", $time, what);
      $display("CHECKS FAILED");
      $finish;
   endtask

   function automatic ctrl_pkg::ctrl_op_t build_op(input ctrl_pkg::op_kind_e kind,
                                                   input logic [15:0] addr,
                                                   input logic [31:0] data);
      ctrl_pkg::ctrl_op_t op;
      op          = '0;
      op.kind     = kind;
      op.pc       = pc_ctr;
      op.spr_addr = addr;
      op.wdata    = data;
      pc_ctr      = pc_ctr + 32'd4;
      return op;
   endfunction

   // Expected result of one op, updates the mirror as the unit would
   function automatic ctrl_pkg::ctrl_res_t model_op(input ctrl_pkg::ctrl_op_t op,
                                                   input logic tick_pend);
      ctrl_pkg::ctrl_res_t r;
      logic                int_ok;
      logic                take;
      logic                next;
      logic [31:0]         off;
      r      = '0;
      off    = '0;
      take   = 1'b1;
      next   = 1'b0;
      int_ok = (op.kind != ctrl_pkg::OP_MTSPR) && (op.kind != ctrl_pkg::OP_RFE);
      if (op.flags.ibus_err) begin
         off = ctrl_pkg::VEC_BERR;
      end else if (op.flags.illegal) begin
         off = ctrl_pkg::VEC_ILLEGAL;
      end else if (op.flags.align) begin
         off = ctrl_pkg::VEC_ALIGN;
      end else if (op.flags.syscall) begin
         off  = ctrl_pkg::VEC_SYSCALL;
         next = 1'b1;
      end else if (op.flags.trap) begin
         off = ctrl_pkg::VEC_TRAP;
      end else if (op.flags.dbus) begin
         off = ctrl_pkg::VEC_BERR;
      end else if (m_picsr != 0 && m_sr[ctrl_pkg::SR_IEE] && int_ok) begin
         off  = ctrl_pkg::VEC_INT;
         next = 1'b1;
      end else if (tick_pend && m_sr[ctrl_pkg::SR_TEE] && int_ok) begin
         off  = ctrl_pkg::VEC_TT;
         next = 1'b1;
      end else begin
         take = 1'b0;
      end
      if (take) begin
         r.redirect    = 1'b1;
         r.redirect_pc = m_evba | off;
         m_esr         = m_sr;
         m_sr[ctrl_pkg::SR_SM]  = 1'b1;
         m_sr[ctrl_pkg::SR_TEE] = 1'b0;
         m_sr[ctrl_pkg::SR_IEE] = 1'b0;
         m_epcr = next ? op.pc + 32'd4 : op.pc;
         m_eear = op.flags.ibus_err ? op.pc : op.lsu_adr;
      end else if (op.kind == ctrl_pkg::OP_RFE) begin
         r.redirect    = 1'b1;
         r.redirect_pc = m_epcr;
         m_sr          = m_esr;
      end else if (op.kind == ctrl_pkg::OP_MFSPR) begin
         case (op.spr_addr)
            ctrl_pkg::SPR_SR:    r.rdata = {16'h0, m_sr};
            ctrl_pkg::SPR_ESR:   r.rdata = {16'h0, m_esr};
            ctrl_pkg::SPR_PPC:   r.rdata = m_ppc;
            ctrl_pkg::SPR_EVBA:  r.rdata = m_evba;
            ctrl_pkg::SPR_EPCR:  r.rdata = m_epcr;
            ctrl_pkg::SPR_EEAR:  r.rdata = m_eear;
            ctrl_pkg::SPR_PICMR: r.rdata = m_picmr;
            ctrl_pkg::SPR_PICSR: r.rdata = m_picsr;
            default:             r.rdata = '0;
         endcase
      end else if (op.kind == ctrl_pkg::OP_MTSPR) begin
         case (op.spr_addr)
            ctrl_pkg::SPR_SR: begin
               if (m_sr[ctrl_pkg::SR_SM]) begin
                  m_sr = (m_sr & ~ctrl_pkg::SR_WMASK) | (op.wdata[15:0] & ctrl_pkg::SR_WMASK);
               end
            end
            ctrl_pkg::SPR_ESR:   m_esr   = op.wdata[15:0];
            ctrl_pkg::SPR_EPCR:  m_epcr  = op.wdata;
            ctrl_pkg::SPR_EVBA:  m_evba  = op.wdata & ~32'h0000_1FFF;
            ctrl_pkg::SPR_PICMR: m_picmr = op.wdata;
            ctrl_pkg::SPR_PICSR: m_picsr = m_picsr & ~op.wdata;
            default:             ;
         endcase
      end
      m_ppc = op.pc;
      return r;
   endfunction

   // One full four-phase transfer
   task automatic retire(input ctrl_pkg::ctrl_op_t op, input logic chk,
                         output ctrl_pkg::ctrl_res_t res);
      int n;
      if (chk) begin
         exp_res = model_op(op, 1'b0);
      end
      check_en = chk;
      @(posedge clk);
      op_i  <= op;
      req_i <= 1'b1;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (!ack_o && n < ACK_LIMIT);
      if (!ack_o) begin
         timed_out("ack_o did not rise after req_i");
      end
      res = res_o;
      req_i <= 1'b0;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (ack_o && n < ACK_LIMIT);
      if (ack_o) begin
         timed_out("ack_o did not fall after req_i dropped");
      end
   endtask

   task automatic round_trip(input logic [15:0] addr, input logic [31:0] data);
      ctrl_pkg::ctrl_res_t res;
      retire(build_op(ctrl_pkg::OP_MTSPR, addr, data), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, addr, 32'h0), 1'b1, res);
   endtask

   task automatic report_test(input string name, input int err0);
      $display("test %-24s %s", name, (n_errors == err0) ? "ok" : "failed");
   endtask

   // Result checked on the first cycle ack_o is seen high
   always @(posedge clk) begin
      if (ack_o && !ack_seen && check_en) begin
         compare("res_o.redirect", {31'h0, res_o.redirect}, {31'h0, exp_res.redirect});
         compare("res_o.redirect_pc", res_o.redirect_pc, exp_res.redirect_pc);
         compare("res_o.rdata", res_o.rdata, exp_res.rdata);
      end
      ack_seen <= ack_o;
   end

   initial begin
      ctrl_pkg::ctrl_op_t  op;
      ctrl_pkg::ctrl_res_t res;
      ctrl_pkg::ctrl_res_t exp;
      logic [31:0]         rnd;
      logic                got_tick;
      int                  i;
      int                  k;
      int                  err0;
      seed     = 32'h3100_926a;
      n_checks = 0;
      n_errors = 0;
      pc_ctr   = 32'h0000_1000;
      check_en = 1'b0;
      ack_seen = 1'b0;
      exp_res  = '0;
      rst      = 1'b1;
      req_i    = 1'b0;
      op_i     = '0;
      irq_i    = '0;
      m_sr     = ctrl_pkg::SR_RESET;
      m_esr    = ctrl_pkg::SR_RESET;
      m_epcr   = '0;
      m_eear   = '0;
      m_evba   = '0;
      m_ppc    = '0;
      m_picmr  = '0;
      m_picsr  = '0;
      repeat (8) @(posedge clk);
      rst <= 1'b0;

      err0 = n_errors;
      retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_SR, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_EVBA, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, 16'h2800, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, 16'h0013, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_PPC, 32'h0), 1'b1, res);
      report_test("reset and unknown", err0);

      err0 = n_errors;
      round_trip(ctrl_pkg::SPR_EVBA, $random(seed));
      round_trip(ctrl_pkg::SPR_ESR, $random(seed));
      round_trip(ctrl_pkg::SPR_EPCR, $random(seed));
      round_trip(ctrl_pkg::SPR_PICMR, $random(seed));
      round_trip(ctrl_pkg::SPR_SR, $random(seed) | 32'h1);
      // Drop supervisor mode, the next SR write must be ignored
      round_trip(ctrl_pkg::SPR_SR, $random(seed) & ~32'h1);
      round_trip(ctrl_pkg::SPR_SR, 32'h0000_0207);
      round_trip(ctrl_pkg::SPR_PICMR, 32'h0);
      report_test("spr round trip", err0);

      err0 = n_errors;
      for (i = 0; i < 8; i++) begin
         op = build_op(ctrl_pkg::OP_PLAIN, 16'h0, 32'h0);
         rnd = $random(seed);
         op.flags = rnd[5:0];
         if (op.flags == '0) begin
            op.flags.trap = 1'b1;
         end
         op.lsu_adr = $random(seed);
         retire(op, 1'b1, res);
         retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_ESR, 32'h0), 1'b1, res);
         retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_EPCR, 32'h0), 1'b1, res);
         retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_EEAR, 32'h0), 1'b1, res);
         retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_SR, 32'h0), 1'b1, res);
      end
      report_test("exception priority", err0);

      err0 = n_errors;
      round_trip(ctrl_pkg::SPR_ESR, 32'h0000_8001 | ($random(seed) & 32'h0000_0206));
      round_trip(ctrl_pkg::SPR_EPCR, $random(seed) & ~32'h3);
      retire(build_op(ctrl_pkg::OP_RFE, 16'h0, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_SR, 32'h0), 1'b1, res);
      report_test("return from exception", err0);

      err0 = n_errors;
      k = $unsigned($random(seed)) % 32;
      round_trip(ctrl_pkg::SPR_PICMR, 32'h1 << k);
      retire(build_op(ctrl_pkg::OP_MTSPR, ctrl_pkg::SPR_SR, 32'h5), 1'b1, res);
      @(posedge clk);
      irq_i <= 32'h1 << k;
      @(posedge clk);
      irq_i <= '0;
      m_picsr = m_picsr | (32'h1 << k);
      retire(build_op(ctrl_pkg::OP_PLAIN, 16'h0, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_PICSR, 32'h0), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MTSPR, ctrl_pkg::SPR_PICSR, 32'h1 << k), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MTSPR, ctrl_pkg::SPR_SR, 32'h5), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_PLAIN, 16'h0, 32'h0), 1'b1, res);
      report_test("pic interrupt", err0);

      err0 = n_errors;
      // Mode 3, IE, period 20
      retire(build_op(ctrl_pkg::OP_MTSPR, ctrl_pkg::SPR_TTMR, 32'hE000_0014), 1'b1, res);
      retire(build_op(ctrl_pkg::OP_MTSPR, ctrl_pkg::SPR_SR, 32'h3), 1'b1, res);
      got_tick = 1'b0;
      i = 0;
      while (!got_tick && i < TICK_TRIES) begin
         op = build_op(ctrl_pkg::OP_PLAIN, 16'h0, 32'h0);
         retire(op, 1'b0, res);
         exp = model_op(op, res.redirect);
         compare("res_o.redirect_pc", res.redirect_pc, exp.redirect_pc);
         got_tick = res.redirect;
         i++;
      end
      if (!got_tick) begin
         n_errors++;
         $display("The tick timer interrupt was never taken");
      end
      op = build_op(ctrl_pkg::OP_MFSPR, ctrl_pkg::SPR_TTMR, 32'h0);
      retire(op, 1'b0, res);
      void'(model_op(op, 1'b0));
      compare("ttmr.ip", {31'h0, res.rdata[ctrl_pkg::TT_IP]}, 32'h1);
      report_test("tick timer interrupt", err0);

      n_errors = n_errors + DUT.u_sva.fail_count;
      $display("%0d checks, %0d errors", n_checks, n_errors);
      if (n_errors == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

//--- ctrl_unit.f
logic/ctrl_pkg.sv
logic/ctrl_retire_seq.sv
logic/sys_spr_file.sv
logic/except_ctrl.sv
logic/tick_timer.sv
logic/pic_ctrl.sv
logic/ctrl_unit.sv
test/ctrl_unit_sva.sv
test/tb_ctrl_unit.sv
